// ==== design/spi_byte_master.sv ====
`timescale 1ns/10ps

// spi mode 0, msb first, sclk idles low
module spi_byte_master (
  input  logic   clk,
  input  logic   rst,
  tdc_spi_if.phy spi,
  output logic   sclk,
  output logic   mosi,
  output logic   cs_n,
  input  logic   miso
);
  import tdc_pkg::*;

  logic              busy;
  logic              last;     // raise cs_n after this byte
  logic [BIT_W-1:0]  bit_cnt;
  logic [DIV_W-1:0]  div_cnt;  // half period divider
  logic [1:0]        hi_cnt;   // cs_n high time left
  logic [BYTE_W-1:0] tx_sr;
  logic [BYTE_W-1:0] rx_sr;
  logic              take;
  logic              tick;
  logic              rise;
  logic              fall;

  assign spi.busy    = busy;
  assign spi.rx_byte = rx_sr;

  assign take = !busy && spi.start;
  assign tick = busy && !cs_n && (div_cnt == DIV_W'(SPI_HALF_DIV - 1));
  assign rise = tick && !sclk;  // sample miso
  assign fall = tick && sclk;   // next mosi bit

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      last    <= 1'b0;
      cs_n    <= 1'b1;
      sclk    <= 1'b0;
      mosi    <= 1'b0;
      bit_cnt <= '0;
      div_cnt <= '0;
      hi_cnt  <= '0;
    end else begin
      if (hi_cnt != 2'd0) hi_cnt <= hi_cnt - 2'd1;
      if (take) begin
        busy    <= 1'b1;
        last    <= spi.cs_end;
        bit_cnt <= '0;
        div_cnt <= '0;
        mosi    <= spi.tx_byte[BYTE_W-1];  // msb ready before first rise
      end else if (busy) begin
        if (spi.cs_end) last <= 1'b1;  // late close request, frame abandoned
        if (cs_n) begin
          // open the frame once min high time is over
          if (hi_cnt == 2'd0) cs_n <= 1'b0;
        end else begin
          div_cnt <= tick ? '0 : div_cnt + 1'b1;
          if (rise) sclk <= 1'b1;
          if (fall) begin
            sclk <= 1'b0;
            if (bit_cnt == BIT_W'(BYTE_W - 1)) begin
              busy <= 1'b0;  // rx_sr complete here
              if (last) begin
                cs_n   <= 1'b1;
                hi_cnt <= CS_HIGH_MIN - 2'd1;
              end
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              mosi    <= tx_sr[BYTE_W-2];
            end
          end
        end
      end else if (!cs_n && spi.cs_end) begin
        // frame dropped between two bytes
        cs_n   <= 1'b1;
        hi_cnt <= CS_HIGH_MIN - 2'd1;
      end
    end
  end

  // shift registers
  always_ff @(posedge clk) begin
    if (take) begin
      tx_sr <= spi.tx_byte;
    end else if (fall) begin
      tx_sr <= {tx_sr[BYTE_W-2:0], 1'b0};
    end
    if (rise) rx_sr <= {rx_sr[BYTE_W-2:0], miso};
  end

  // sequencer must wait for busy low
  assert property (@(posedge clk) disable iff (rst) spi.start |-> !busy)
    else $error("spi start while engine busy");

endmodule

// ==== design/tdc_cmd_rom.sv ====
`timescale 1ns/10ps

module tdc_cmd_rom (
  input  logic                       clk,
  input  logic [tdc_pkg::ROM_AW-1:0] addr,
  output logic [7:0]                 data
);
  import tdc_pkg::*;

  logic [BYTE_W-1:0]   rom_byte;
  logic [2*BYTE_W-1:0] cfg_word;

  // config section, two rom entries per table row
  always_comb begin
    cfg_word = '0;
    if (addr <= ADDR_CFG_LAST) begin
      cfg_word = CFG_TABLE[addr[ROM_AW-1:1]];
    end
  end

  always_comb begin
    rom_byte = DUMMY_BYTE;  // read padding by default
    if (addr <= ADDR_CFG_LAST) begin
      // even entry is the cmd byte, odd the data
      if (addr[0]) begin
        rom_byte = cfg_word[BYTE_W-1:0];
      end else begin
        rom_byte = cfg_word[2*BYTE_W-1:BYTE_W];
      end
    end else begin
      case (addr)
        ADDR_TRIG:        rom_byte = WR_CMD | REG_CONFIG1;
        ADDR_TRIG + 1'b1: rom_byte = TRIG_DATA;  // start_meas
        ADDR_TIME1:       rom_byte = REG_TIME1;
        ADDR_CALIB1:      rom_byte = REG_CALIB1;
        ADDR_CALIB2:      rom_byte = REG_CALIB2;
        default:          rom_byte = DUMMY_BYTE;
      endcase
    end
  end

  // one cycle latency
  always_ff @(posedge clk) begin
    data <= rom_byte;
  end

endmodule

// ==== design/tdc_pkg.sv ====
package tdc_pkg;

  // basic sizes
  localparam int BYTE_W = 8;
  localparam int BIT_W  = $clog2(BYTE_W);    // bit index inside a byte
  localparam int ROM_AW = 5;                 // 32 rom entries

  // spi clocking
  localparam int SPI_HALF_DIV = 4;           // clk cycles per sclk half period
  localparam int DIV_W        = $clog2(SPI_HALF_DIV);
  localparam logic [1:0] CS_HIGH_MIN = 2'd2; // min cs_n high time between frames

  // shot timing, clk cycles
  localparam logic [15:0] SHOT_PERIOD  = 16'd2000; // end of shot to next trigger
  localparam logic [15:0] TRIG_GAP     = 16'd5;    // trigger frame end to start rise
  localparam logic [15:0] START_LEN    = 16'd3;
  localparam logic [15:0] INTB_TIMEOUT = 16'd100;

  // time1 values the chip reports for a missed stop
  localparam logic [15:0] TIME1_BAD_A = 16'h0000;
  localparam logic [15:0] TIME1_BAD_B = 16'h0700;

  // rom address map
  localparam logic [ROM_AW-1:0] ADDR_CFG_FIRST = 5'd0;
  localparam logic [ROM_AW-1:0] ADDR_CFG_LAST  = 5'd17; // 9 frames of cmd + data
  localparam logic [ROM_AW-1:0] ADDR_TRIG      = 5'd18; // cmd at 18, data at 19
  localparam logic [ROM_AW-1:0] ADDR_TIME1     = 5'd20;
  localparam logic [ROM_AW-1:0] ADDR_CALIB1    = 5'd24;
  localparam logic [ROM_AW-1:0] ADDR_CALIB2    = 5'd28;

  // chip command bytes and registers
  localparam logic [BYTE_W-1:0] WR_CMD      = 8'h40; // write bit, or'ed with reg number
  localparam logic [BYTE_W-1:0] REG_CONFIG1 = 8'h00;
  localparam logic [BYTE_W-1:0] REG_TIME1   = 8'h10;
  localparam logic [BYTE_W-1:0] REG_CALIB1  = 8'h1B;
  localparam logic [BYTE_W-1:0] REG_CALIB2  = 8'h1C;
  localparam logic [BYTE_W-1:0] TRIG_DATA   = 8'h03; // start_meas, mode 2
  localparam logic [BYTE_W-1:0] DUMMY_BYTE  = 8'h00; // clocks out read data

  // power-up register writes, {cmd, data}
  localparam int CFG_N = 9;
  localparam logic [2*BYTE_W-1:0] CFG_TABLE [CFG_N] = '{
    16'h4002,  // config1, mode 2, no start yet
    16'h4140,  // config2, 10 calibration periods
    16'h421F,  // int_status, clear all flags
    16'h4307,  // int_mask, all interrupts on
    16'h44FF,  // coarse counter overflow hi
    16'h45FF,  // coarse counter overflow lo
    16'h46FF,  // clock counter overflow hi
    16'h47FF,  // clock counter overflow lo
    16'h4800   // clock counter stop mask hi
  };

  // sequencer states
  localparam int ST_W = 4;
  localparam logic [ST_W-1:0] ST_IDLE      = 4'd0;
  localparam logic [ST_W-1:0] ST_CFG       = 4'd1;
  localparam logic [ST_W-1:0] ST_SHOT_WAIT = 4'd2;
  localparam logic [ST_W-1:0] ST_TRIG      = 4'd3;
  localparam logic [ST_W-1:0] ST_TRIG_GAP  = 4'd4;
  localparam logic [ST_W-1:0] ST_START     = 4'd5;
  localparam logic [ST_W-1:0] ST_INTB_WAIT = 4'd6;
  localparam logic [ST_W-1:0] ST_RD_TIME1  = 4'd7;
  localparam logic [ST_W-1:0] ST_RD_CALIB1 = 4'd8;
  localparam logic [ST_W-1:0] ST_RD_CALIB2 = 4'd9;
  localparam logic [ST_W-1:0] ST_CHECK     = 4'd10;
  localparam logic [ST_W-1:0] ST_HOLD      = 4'd11;
  localparam logic [ST_W-1:0] ST_PAUSE     = 4'd12;

endpackage

// ==== design/tdc_sequencer.sv ====
`timescale 1ns/10ps

module tdc_sequencer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       soft_reset,
  input  logic                       pause,
  input  logic                       intb,
  input  logic                       result_done,
  tdc_spi_if.ctrl                    spi,
  output logic [tdc_pkg::ROM_AW-1:0] rom_addr,
  output logic                       start_pulse,
  output logic                       result_valid,
  output logic                       bad_meas,
  output logic                       intb_timeout,
  output logic [31:0]                result_data
);
  import tdc_pkg::*;

  logic [ST_W-1:0] state;
  logic [15:0]     tmr;       // shot, gap, pulse and timeout counter
  logic [1:0]      byte_cnt;  // byte inside the current frame
  logic            arm;       // address set, strobe next cycle
  logic            inflight;  // byte handed to the engine
  logic            start_q;
  logic            cs_end_q;
  logic [15:0]     time1;
  logic [15:0]     calib1;
  logic [15:0]     calib2;
  logic [15:0]     calib_diff;
  logic            is_read;
  logic            byte_done;
  logic            frame_last;
  logic            time1_bad;

  assign spi.start  = start_q;
  assign spi.cs_end = cs_end_q;

  assign is_read = (state == ST_RD_TIME1) || (state == ST_RD_CALIB1) ||
                   (state == ST_RD_CALIB2);
  // busy still low on the strobe cycle, so skip it
  assign byte_done  = inflight && !start_q && !spi.busy;
  // last frame of the state, config has nine
  assign frame_last = cs_end_q && ((state != ST_CFG) || (rom_addr == ADDR_CFG_LAST));
  assign calib_diff = calib2 - calib1;  // wraps mod 2^16
  assign time1_bad  = (time1 == TIME1_BAD_A) || (time1 == TIME1_BAD_B);

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= ST_IDLE;
      rom_addr     <= ADDR_CFG_FIRST;
      tmr          <= '0;
      byte_cnt     <= '0;
      arm          <= 1'b0;
      inflight     <= 1'b0;
      start_q      <= 1'b0;
      cs_end_q     <= 1'b0;
      start_pulse  <= 1'b0;
      result_valid <= 1'b0;
      bad_meas     <= 1'b0;
      intb_timeout <= 1'b0;
    end else begin
      start_q      <= 1'b0;
      bad_meas     <= 1'b0;
      intb_timeout <= 1'b0;
      if (result_valid && result_done) result_valid <= 1'b0;  // consumer took it

      // rom data valid now, hand the byte over
      if (arm) begin
        arm      <= 1'b0;
        start_q  <= 1'b1;
        inflight <= 1'b1;
        cs_end_q <= is_read ? (byte_cnt == 2'd3) : byte_cnt[0];  // 4 or 2 byte frames
      end

      if (byte_done) begin
        inflight <= 1'b0;
        byte_cnt <= cs_end_q ? 2'd0 : byte_cnt + 2'd1;
        if (!frame_last) begin
          rom_addr <= rom_addr + 1'b1;
          arm      <= 1'b1;
        end
      end

      case (state)
        ST_IDLE: begin
          if (soft_reset) begin
            state    <= ST_CFG;
            rom_addr <= ADDR_CFG_FIRST;
            arm      <= 1'b1;
          end
        end
        ST_CFG: begin
          if (byte_done && frame_last) begin
            state <= ST_SHOT_WAIT;
            tmr   <= '0;
          end
        end
        ST_SHOT_WAIT: begin
          if (tmr == SHOT_PERIOD - 16'd1) begin
            state    <= ST_TRIG;
            rom_addr <= ADDR_TRIG;
            arm      <= 1'b1;
          end else begin
            tmr <= tmr + 16'd1;
          end
        end
        ST_TRIG: begin
          if (byte_done && frame_last) begin
            state <= ST_TRIG_GAP;
            tmr   <= 16'd1;  // cs_n rose one cycle ago
          end
        end
        ST_TRIG_GAP: begin
          if (tmr == TRIG_GAP - 16'd1) begin
            state       <= ST_START;
            start_pulse <= 1'b1;
            tmr         <= '0;
          end else begin
            tmr <= tmr + 16'd1;
          end
        end
        ST_START: begin
          if (tmr == START_LEN - 16'd1) begin
            state       <= ST_INTB_WAIT;
            start_pulse <= 1'b0;
            tmr         <= '0;
          end else begin
            tmr <= tmr + 16'd1;
          end
        end
        ST_INTB_WAIT: begin
          if (!intb) begin  // measurement done in chip
            state    <= ST_RD_TIME1;
            rom_addr <= ADDR_TIME1;
            arm      <= 1'b1;
          end else if (tmr == INTB_TIMEOUT - 16'd1) begin
            state        <= ST_SHOT_WAIT;
            intb_timeout <= 1'b1;
            tmr          <= '0;
          end else begin
            tmr <= tmr + 16'd1;
          end
        end
        ST_RD_TIME1: begin
          if (byte_done && frame_last) begin
            state    <= ST_RD_CALIB1;
            rom_addr <= ADDR_CALIB1;
            arm      <= 1'b1;
          end
        end
        ST_RD_CALIB1: begin
          if (byte_done && frame_last) begin
            state    <= ST_RD_CALIB2;
            rom_addr <= ADDR_CALIB2;
            arm      <= 1'b1;
          end
        end
        ST_RD_CALIB2: begin
          if (byte_done && frame_last) state <= ST_CHECK;
        end
        ST_CHECK: begin
          if (time1_bad) begin
            state    <= ST_SHOT_WAIT;
            bad_meas <= 1'b1;
            tmr      <= '0;
          end else begin
            state        <= ST_HOLD;
            result_valid <= 1'b1;
          end
        end
        ST_HOLD: begin
          // shot timer stopped until the word is taken
          if (result_done) begin
            state <= ST_SHOT_WAIT;
            tmr   <= '0;
          end
        end
        ST_PAUSE: begin
          if (!pause) begin
            state <= (result_valid && !result_done) ? ST_HOLD : ST_SHOT_WAIT;
            tmr   <= '0;
          end
        end
        default: state <= ST_IDLE;
      endcase

      // config always runs to its end
      if (pause && (state != ST_IDLE) && (state != ST_CFG)) begin
        state       <= ST_PAUSE;
        arm         <= 1'b0;
        inflight    <= 1'b0;
        start_q     <= 1'b0;
        cs_end_q    <= 1'b1;  // engine closes the open frame
        byte_cnt    <= '0;
        start_pulse <= 1'b0;
      end
    end
  end

  // data bytes 3 and 4 of each read frame
  always_ff @(posedge clk) begin
    if (byte_done && byte_cnt[1]) begin
      case (state)
        ST_RD_TIME1:  time1  <= {time1[BYTE_W-1:0], spi.rx_byte};
        ST_RD_CALIB1: calib1 <= {calib1[BYTE_W-1:0], spi.rx_byte};
        ST_RD_CALIB2: calib2 <= {calib2[BYTE_W-1:0], spi.rx_byte};
        default: ;
      endcase
    end
    if (state == ST_CHECK) result_data <= {calib_diff, time1};
  end

  assert property (@(posedge clk) disable iff (rst)
    result_valid && !result_done |=> result_valid && $stable(result_data))
    else $error("result word dropped or changed before result_done");

endmodule

// ==== design/tdc_spi_if.sv ====
`timescale 1ns/10ps

// one spi byte transfer, sequencer side and engine side
interface tdc_spi_if;
  import tdc_pkg::*;

  logic              start;    // 1-cycle strobe, only while !busy
  logic [BYTE_W-1:0] tx_byte;  // from rom, valid with start
  logic              cs_end;   // byte closes the frame
  logic [BYTE_W-1:0] rx_byte;  // valid from busy fall
  logic              busy;

  modport ctrl (
    output start,
    output cs_end,
    input  rx_byte,
    input  busy
  );

  // tx_byte comes straight from the rom register
  modport phy (
    input  start,
    input  tx_byte,
    input  cs_end,
    output rx_byte,
    output busy
  );

endinterface

// ==== design/tdc_subsys.sv ====
`timescale 1ns/10ps

module tdc_subsys (
  input  logic        clk,
  input  logic        rst,
  input  logic        soft_reset,    // starts chip configuration
  input  logic        pause,
  output logic        sclk,
  output logic        mosi,
  input  logic        miso,
  output logic        cs_n,
  output logic        start_pulse,   // to chip start input
  input  logic        intb,          // chip interrupt, active low
  output logic [31:0] result_data,   // {calib2 - calib1, time1}
  output logic        result_valid,
  input  logic        result_done,
  output logic        bad_meas,
  output logic        intb_timeout
);
  import tdc_pkg::*;

  logic [ROM_AW-1:0] rom_addr;

  tdc_spi_if spi ();

  tdc_sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .soft_reset   (soft_reset),
    .pause        (pause),
    .intb         (intb),
    .result_done  (result_done),
    .spi          (spi),
    .rom_addr     (rom_addr),
    .start_pulse  (start_pulse),
    .result_valid (result_valid),
    .bad_meas     (bad_meas),
    .intb_timeout (intb_timeout),
    .result_data  (result_data)
  );

  // rom output feeds the engine byte input directly
  tdc_cmd_rom u_rom (
    .clk  (clk),
    .addr (rom_addr),
    .data (spi.tx_byte)
  );

  spi_byte_master u_spi (
    .clk  (clk),
    .rst  (rst),
    .spi  (spi),
    .sclk (sclk),
    .mosi (mosi),
    .cs_n (cs_n),
    .miso (miso)
  );

endmodule

// ==== dv/tdc_chip_model.sv ====
`timescale 1ns/10ps

// behavioral tdc chip, spi mode 0 slave plus intb
module tdc_chip_model (
  input  logic        clk,
  input  logic        sclk,
  input  logic        mosi,
  output logic        miso,
  input  logic        cs_n,
  input  logic        start_pulse,
  output logic        intb,
  input  logic [23:0] time1_val,   // full 24-bit register contents
  input  logic [23:0] calib1_val,
  input  logic [23:0] calib2_val,
  input  logic        intb_en,     // low means the stop never comes
  input  int          intb_delay   // clk cycles from start_pulse fall to intb low
);
  import tdc_pkg::*;

  logic [31:0] frame_data [256];  // bytes in arrival order, newest in [7:0]
  int          frame_len  [256];
  int          frame_cnt = 0;     // closed frames
  int          bit_cnt;
  int          wait_cnt;
  logic [7:0]  rx_sr;
  logic [23:0] tx_sr;             // read data still to shift out
  logic        miso_q;
  logic        intb_q;
  logic        sclk_q;
  logic        cs_q;
  logic        sp_q;

  assign miso = miso_q;
  assign intb = intb_q;

  initial begin
    bit_cnt  = 0;
    wait_cnt = 0;
    miso_q   = 1'b0;
    intb_q   = 1'b1;  // idle high, active low
    sclk_q   = 1'b0;
    cs_q     = 1'b1;
    sp_q     = 1'b0;
  end

  // register number in the command byte picks the read value
  function automatic logic [23:0] reg_value(input logic [7:0] cmd);
    case (cmd)
      8'h10:   return time1_val;
      8'h1B:   return calib1_val;
      8'h1C:   return calib2_val;
      default: return 24'h0;
    endcase
  endfunction

  // pins looked at on the falling clk edge, half a cycle from dut updates
  always @(negedge clk) begin
    if (cs_q && !cs_n) begin  // frame opens
      bit_cnt               = 0;
      frame_data[frame_cnt] = '0;
      frame_len[frame_cnt]  = 0;
      miso_q                = 1'b0;
    end
    if (!cs_n && !sclk_q && sclk) begin  // sclk rise, take mosi
      rx_sr = {rx_sr[6:0], mosi};
      bit_cnt++;
      if (bit_cnt % 8 == 0) begin
        frame_data[frame_cnt] = {frame_data[frame_cnt][23:0], rx_sr};
        frame_len[frame_cnt]++;
        if (bit_cnt == 8) tx_sr = reg_value(rx_sr);  // command byte done
      end
    end
    if (!cs_n && sclk_q && !sclk && bit_cnt >= 8) begin  // sclk fall, next read bit
      miso_q = tx_sr[23];
      tx_sr  = {tx_sr[22:0], 1'b0};
    end
    if (!cs_q && cs_n) begin  // frame closes
      if (frame_len[frame_cnt] == 2 && frame_data[frame_cnt][15:0] == {WR_CMD, TRIG_DATA})
        intb_q = 1'b1;  // start_meas rearms the interrupt
      frame_cnt <= frame_cnt + 1;
    end
    if (sp_q && !start_pulse && intb_en) begin
      wait_cnt = intb_delay;
    end else if (wait_cnt > 0) begin
      wait_cnt--;
      if (wait_cnt == 0) intb_q = 1'b0;  // measurement complete
    end
    cs_q   = cs_n;
    sclk_q = sclk;
    sp_q   = start_pulse;
  end

endmodule

// ==== dv/tdc_subsys_tb.sv ====
`timescale 1ns/10ps

module tdc_subsys_tb;
  import tdc_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int SHOT_BUDGET = 4000;  // clk cycles allowed per shot
  localparam int WATCHDOG_NS = 12 * SHOT_BUDGET * CLK_PERIOD;
  localparam int HOLD_CYCLES = 2500;  // longer than one shot period
  localparam int PAUSE_AFTER = 3 * int'(SHOT_PERIOD) / 4;  // shot timer part way up
  localparam int OUT_NONE    = 0;
  localparam int OUT_RESULT  = 1;
  localparam int OUT_BAD     = 2;
  localparam int OUT_TIMEOUT = 3;
  localparam logic [7:0] READ_REGS [3] = '{8'h10, 8'h1B, 8'h1C};  // time1, calib1, calib2

  logic        clk = 1'b0;
  logic        rst, soft_reset, pause, result_done;
  logic        sclk, mosi, miso, cs_n;
  logic        start_pulse, intb;
  logic [31:0] result_data;
  logic        result_valid, bad_meas, intb_timeout;
  logic [23:0] time1_val, calib1_val, calib2_val;  // what the chip reports
  logic        intb_en;
  int          intb_delay;
  logic [31:0] lcg_state = 32'd19;
  int          errors = 0;
  int          checks = 0;
  int          since_cs = 0;    // falling edges since cs_n rose
  int          since_sp = 0;    // falling edges since start_pulse fell
  int          sp_len   = 0;    // start_pulse high samples
  logic        cs_prev  = 1'b1;
  logic        sp_prev  = 1'b0;

  tdc_subsys dut (.*);
  tdc_chip_model chip (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin  // watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests stalled", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [23:0] rand24();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:8];  // high bits, low ones cycle fast
  endfunction

  function automatic logic [23:0] rand_time1();
    logic [23:0] v;
    v = rand24();
    while (v[15:0] == TIME1_BAD_A || v[15:0] == TIME1_BAD_B) v = rand24();
    return v;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
  endtask

  // start_pulse and intb_timeout spacing, counted in falling edges
  always @(negedge clk) begin
    if (cs_n && !cs_prev) since_cs = 0;  // frame just closed
    else since_cs++;
    if (!start_pulse && sp_prev) since_sp = 0;
    else since_sp++;
    if (start_pulse && !sp_prev) begin
      checks++;
      if (since_cs != int'(TRIG_GAP))
        report_mismatch("start_pulse delay", 32'(since_cs), 32'(TRIG_GAP));
      sp_len = 0;
    end
    if (start_pulse) sp_len++;
    if (!start_pulse && sp_prev) begin
      checks++;
      if (sp_len != int'(START_LEN))
        report_mismatch("start_pulse length", 32'(sp_len), 32'(START_LEN));
    end
    if (intb_timeout) begin
      checks++;
      if (since_sp != int'(INTB_TIMEOUT))
        report_mismatch("intb_timeout delay", 32'(since_sp), 32'(INTB_TIMEOUT));
    end
    cs_prev = cs_n;
    sp_prev = start_pulse;
  end

  // first of result_valid, bad_meas or intb_timeout
  task automatic wait_outcome(output int kind, output int waited);
    kind   = OUT_NONE;
    waited = 0;
    while (kind == OUT_NONE && waited < SHOT_BUDGET) begin
      @(negedge clk);
      waited++;
      if (result_valid) kind = OUT_RESULT;
      else if (bad_meas) kind = OUT_BAD;
      else if (intb_timeout) kind = OUT_TIMEOUT;
    end
    if (kind == OUT_NONE) begin
      errors++;
      $display("no result, rejection or intb timeout within %0d cycles", SHOT_BUDGET);
    end
  endtask

  task automatic consume_result();
    result_done = 1'b1;
    @(negedge clk);
    result_done = 1'b0;
    checks++;
    if (result_valid !== 1'b0) report_mismatch("result_valid", 32'(result_valid), 32'h0);
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    checks++;
    if (result_valid !== 1'b0) report_mismatch("result_valid", 32'(result_valid), 32'h0);
    if (start_pulse !== 1'b0) report_mismatch("start_pulse", 32'(start_pulse), 32'h0);
    if (bad_meas !== 1'b0) report_mismatch("bad_meas", 32'(bad_meas), 32'h0);
    if (intb_timeout !== 1'b0) report_mismatch("intb_timeout", 32'(intb_timeout), 32'h0);
    if (cs_n !== 1'b1) report_mismatch("cs_n", 32'(cs_n), 32'h1);
  endtask

  // one shot with valid registers, checks word and the four frames
  task automatic good_shot(input int min_cycles, input bit hold, output logic [31:0] expected);
    logic [23:0] t1;
    logic [23:0] c1;
    logic [23:0] c2;
    int base;
    int kind;
    int waited;
    int i;
    t1 = rand_time1();
    c1 = rand24();
    c2 = rand24();
    time1_val  = t1;
    calib1_val = c1;
    calib2_val = c2;
    intb_en    = 1'b1;
    intb_delay = 2 + int'(rand24() % 24'd60);  // well inside INTB_TIMEOUT
    expected   = {c2[15:0] - c1[15:0], t1[15:0]};
    base = chip.frame_cnt;
    wait_outcome(kind, waited);
    checks++;
    if (kind != OUT_RESULT) begin
      errors++;
      $display("good shot ended without a result word, outcome %0d", kind);
      return;
    end
    checks++;
    if (waited < min_cycles) begin
      errors++;
      $display("result after %0d cycles, under the %0d cycle shot period", waited, min_cycles);
    end
    checks++;
    if (result_data !== expected) report_mismatch("result_data", result_data, expected);
    checks++;
    if (chip.frame_cnt - base != 4) begin
      errors++;
      $display("good shot had %0d frames instead of 4", chip.frame_cnt - base);
    end else begin
      checks++;
      if (chip.frame_data[base] !== {16'h0, WR_CMD, TRIG_DATA})
        report_mismatch("chip.frame_data trigger", chip.frame_data[base],
                        {16'h0, WR_CMD, TRIG_DATA});
      for (i = 0; i < 3; i++) begin
        checks++;
        if (chip.frame_data[base + 1 + i] !== {READ_REGS[i], 24'h0})
          report_mismatch("chip.frame_data read", chip.frame_data[base + 1 + i],
                          {READ_REGS[i], 24'h0});
      end
    end
    if (!hold) consume_result();
  endtask

  task automatic bad_shot(input logic [15:0] t1_low);
    logic [23:0] v;
    int kind;
    int waited;
    v = rand24();
    time1_val  = {v[23:16], t1_low};  // upper byte is ignored by the dut
    calib1_val = rand24();
    calib2_val = rand24();
    intb_en    = 1'b1;
    wait_outcome(kind, waited);
    checks++;
    if (kind != OUT_BAD) begin
      errors++;
      $display("TIME1 0x%h was not rejected, outcome %0d", t1_low, kind);
      if (kind == OUT_RESULT) consume_result();
    end
  endtask

  task automatic config_frames();
    int n;
    int i;
    soft_reset = 1'b1;
    @(negedge clk);
    soft_reset = 1'b0;
    n = 0;
    while (chip.frame_cnt < CFG_N && n < SHOT_BUDGET) begin
      @(negedge clk);
      n++;
    end
    checks++;
    if (chip.frame_cnt < CFG_N) begin
      errors++;
      $display("only %0d config frames within %0d cycles", chip.frame_cnt, SHOT_BUDGET);
    end
    for (i = 0; i < CFG_N; i++) begin
      checks++;
      if (chip.frame_len[i] != 2)
        report_mismatch($sformatf("chip.frame_len[%0d]", i), 32'(chip.frame_len[i]), 32'd2);
      checks++;
      if (chip.frame_data[i] !== {16'h0, CFG_TABLE[i]})
        report_mismatch($sformatf("chip.frame_data[%0d]", i), chip.frame_data[i],
                        {16'h0, CFG_TABLE[i]});
    end
  endtask

  task automatic single_measurement();
    logic [31:0] expected;
    good_shot(int'(SHOT_PERIOD), 1'b0, expected);
  endtask

  task automatic rejection_recovery();
    logic [31:0] expected;
    bad_shot(TIME1_BAD_A);
    bad_shot(TIME1_BAD_B);
    good_shot(int'(SHOT_PERIOD), 1'b0, expected);  // recovers on the next shot
  endtask

  task automatic timeout_recovery();
    logic [31:0] expected;
    int base;
    int kind;
    int waited;
    intb_en = 1'b0;
    base = chip.frame_cnt;
    wait_outcome(kind, waited);
    checks++;
    if (kind != OUT_TIMEOUT) begin
      errors++;
      $display("missing interrupt did not raise intb_timeout, outcome %0d", kind);
    end
    checks++;
    if (chip.frame_cnt - base != 1) begin  // trigger only
      errors++;
      $display("timed out shot had %0d frames instead of 1", chip.frame_cnt - base);
    end
    good_shot(int'(SHOT_PERIOD), 1'b0, expected);
  endtask

  task automatic backpressure_and_pause();
    logic [31:0] expected;
    int base;
    int i;
    bit dropped;
    good_shot(int'(SHOT_PERIOD), 1'b1, expected);
    base = chip.frame_cnt;
    dropped = 1'b0;
    checks++;
    for (i = 0; i < HOLD_CYCLES && !dropped; i++) begin
      @(negedge clk);
      if (result_valid !== 1'b1) begin
        report_mismatch("result_valid", 32'(result_valid), 32'h1);
        dropped = 1'b1;
      end
      if (result_data !== expected) begin
        report_mismatch("result_data", result_data, expected);
        dropped = 1'b1;
      end
      if (chip.frame_cnt != base) begin
        errors++;
        $display("spi frame sent at hold cycle %0d before result_done", i);
        dropped = 1'b1;
      end
    end
    consume_result();
    repeat (PAUSE_AFTER) @(negedge clk);  // pause lands mid shot wait
    pause = 1'b1;
    repeat (HOLD_CYCLES) @(negedge clk);
    checks++;
    if (chip.frame_cnt != base) begin
      errors++;
      $display("%0d spi frames sent during shot wait or pause", chip.frame_cnt - base);
    end
    checks++;
    if (start_pulse !== 1'b0) report_mismatch("start_pulse", 32'(start_pulse), 32'h0);
    pause = 1'b0;
    good_shot(int'(SHOT_PERIOD), 1'b0, expected);  // timer starts over from zero
  endtask

  initial begin
    rst         = 1'b1;
    soft_reset  = 1'b0;
    pause       = 1'b0;
    result_done = 1'b0;
    time1_val   = '0;
    calib1_val  = '0;
    calib2_val  = '0;
    intb_en     = 1'b1;
    intb_delay  = 20;
    apply_reset();
    config_frames();
    single_measurement();
    rejection_recovery();
    timeout_recovery();
    backpressure_and_pause();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the tdc subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tdc_subsys_tb \
  --Mdir obj_dir \
  -f tdc_subsys.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtdc_subsys_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# verdict comes from the testbench's own closing line
if echo "$sim_out" | grep -Fqx "Simulation passed"; then
  exit 0
fi
exit 1

// ==== tdc_subsys.f ====
design/tdc_pkg.sv
design/tdc_spi_if.sv
design/tdc_cmd_rom.sv
design/spi_byte_master.sv
design/tdc_sequencer.sv
design/tdc_subsys.sv
dv/tdc_chip_model.sv
dv/tdc_subsys_tb.sv
